//--- common/elevator_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared definitions for the elevator floor request controller
// Floor count, floor number and floor mask types
// Car status and car command structs
//////////////////////////////////////////////////////////////////////

package elevator_pkg;

    //////////////////////////////////////////////////////////////////////
    // Building size
    //////////////////////////////////////////////////////////////////////

    // Floors are numbered 0 (lowest) to NUM_FLOORS-1
    localparam int NUM_FLOORS = 11;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    // Floor number, 0 for the lowest floor up to 10 for the highest
    typedef logic [3:0] floor_t;

    // One bit per floor, bit 0 is the lowest floor
    // Used for the button inputs and the request lights
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    // Status reported by the car's motion control
    typedef struct packed {
        floor_t current_floor;
        logic   moving;
    } car_status_t;

    // Command sent to the car's motion control
    typedef struct packed {
        floor_t target_floor;
        // 1 means up
        logic   direction_up;
        logic   activate;
    } car_command_t;

endpackage

//--- hdl/request_latch.sv
//////////////////////////////////////////////////////////////////////
// Request latch for the elevator floor controller
// Samples hall call and car panel buttons, picks one new request
// per cycle, holds the request lights and clears them on arrival
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module request_latch (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      emergency_button,
    input  logic                      power_switch,
    input  elevator_pkg::car_status_t car_status,
    input  logic                      full,
    output elevator_pkg::floor_mask_t call_lights,
    output elevator_pkg::floor_mask_t panel_lights,
    output logic                      push,
    output elevator_pkg::floor_t      push_floor
);

    import elevator_pkg::*;

    floor_mask_t here_mask;
    floor_mask_t panel_cand;
    floor_mask_t call_cand;
    floor_mask_t select_mask;
    floor_mask_t panel_set;
    floor_mask_t call_set;
    floor_mask_t clear_mask;
    logic        sel_found;
    logic        sel_is_panel;
    logic        accept_enable;

    // Requests are only taken with power on and no emergency
    assign accept_enable = power_switch && !emergency_button;

    // Decode the floor the car stands at
    always_comb begin
        for (int i = 0; i < NUM_FLOORS; i++) begin
            here_mask[i] = (car_status.current_floor == floor_t'(i));
        end
    end

    // A floor is a candidate when pressed, unlit and not the current floor
    assign panel_cand = panel_buttons & ~panel_lights & ~here_mask;
    assign call_cand  = floor_call_buttons & ~call_lights & ~here_mask;

    //////////////////////////////////////////////////////////////////////
    // Priority pick: panel floors lowest first, then call floors
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sel_found    = 1'b0;
        sel_is_panel = 1'b0;
        select_mask  = '0;
        push_floor   = '0;
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (!sel_found && panel_cand[i]) begin
                sel_found      = 1'b1;
                sel_is_panel   = 1'b1;
                select_mask[i] = 1'b1;
                push_floor     = floor_t'(i);
            end
        end
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (!sel_found && call_cand[i]) begin
                sel_found      = 1'b1;
                select_mask[i] = 1'b1;
                push_floor     = floor_t'(i);
            end
        end
    end

    // Held off entirely while the queue has no room
    assign push = accept_enable && !full && sel_found;

    assign panel_set = (push && sel_is_panel) ? select_mask : '0;
    assign call_set  = (push && !sel_is_panel) ? select_mask : '0;

    // Standing at a floor clears both of its lights, emergency or not
    assign clear_mask = (power_switch && !car_status.moving) ? here_mask : '0;

    //////////////////////////////////////////////////////////////////////
    // Light registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_lights <= '0;
            call_lights  <= '0;
        end else begin
            panel_lights <= (panel_lights | panel_set) & ~clear_mask;
            call_lights  <= (call_lights | call_set) & ~clear_mask;
        end
    end

endmodule

//--- hdl/request_queue.sv
//////////////////////////////////////////////////////////////////////
// Request queue for the elevator floor controller
// Circular buffer of requested floor numbers, oldest at the head
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module request_queue #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 push,
    input  elevator_pkg::floor_t push_floor,
    input  logic                 pop,
    output elevator_pkg::floor_t head_floor,
    output logic                 head_valid,
    output logic                 full
);

    import elevator_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    floor_t entries [QUEUE_DEPTH];
    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    cnt_t   count;
    logic   do_push;
    logic   do_pop;

    // Guard both sides so a stray strobe cannot corrupt the pointers
    assign do_push = push && !full;
    assign do_pop  = pop && head_valid;

    assign head_valid = (count != '0);
    assign full       = (count == cnt_t'(QUEUE_DEPTH));
    assign head_floor = entries[rd_ptr];

    // Step a pointer with wrap, depth need not be a power of two
    function automatic ptr_t next_ptr(input ptr_t ptr);
        if (ptr == ptr_t'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + ptr_t'(1);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (do_push) begin
            entries[wr_ptr] <= push_floor;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leave the count unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/car_dispatch.sv
//////////////////////////////////////////////////////////////////////
// Car dispatch for the elevator floor controller
// Target, direction and activate toward the car
// Retires the head request on arrival, gates the door buttons
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module car_dispatch (
    input  logic                       power_switch,
    input  logic                       emergency_button,
    input  logic                       door_open_button,
    input  logic                       door_close_button,
    input  elevator_pkg::car_status_t  car_status,
    input  elevator_pkg::floor_t       head_floor,
    input  logic                       head_valid,
    output elevator_pkg::car_command_t car_command,
    output logic                       pop,
    output logic                       door_open_allowed,
    output logic                       door_close_allowed
);

    import elevator_pkg::*;

    floor_t target;
    logic   stopped;
    logic   at_head;

    // Powered and standing still
    assign stopped = power_switch && !car_status.moving;
    assign at_head = (head_floor == car_status.current_floor);

    // An empty queue points the car at floor 0 without activating it
    assign target = head_valid ? head_floor : '0;

    //////////////////////////////////////////////////////////////////////
    // Command toward the car
    //////////////////////////////////////////////////////////////////////

    assign car_command.target_floor = target;
    assign car_command.direction_up = (target > car_status.current_floor);
    assign car_command.activate     = stopped && !emergency_button && head_valid && !at_head;

    // Arrival at the head floor, or a stale duplicate of the current floor
    assign pop = stopped && head_valid && at_head;

    //////////////////////////////////////////////////////////////////////
    // Door gating
    //////////////////////////////////////////////////////////////////////

    assign door_open_allowed  = stopped && door_open_button;
    assign door_close_allowed = stopped && door_close_button;

endmodule

//--- hdl/floor_controller.sv
//////////////////////////////////////////////////////////////////////
// Top level of the elevator floor request controller
// Connects the request latch, the request queue and car dispatch
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module floor_controller #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                       clock,
    input  logic                       reset_n,
    // Buttons from halls and car panel
    input  elevator_pkg::floor_mask_t  floor_call_buttons,
    input  elevator_pkg::floor_mask_t  panel_buttons,
    input  logic                       door_open_button,
    input  logic                       door_close_button,
    input  logic                       emergency_button,
    input  logic                       power_switch,
    // Motion control interface
    input  elevator_pkg::car_status_t  car_status,
    output elevator_pkg::car_command_t car_command,
    // Lights and door permissions
    output elevator_pkg::floor_mask_t  call_lights,
    output elevator_pkg::floor_mask_t  panel_lights,
    output logic                       door_open_allowed,
    output logic                       door_close_allowed
);

    import elevator_pkg::*;

    logic   push;
    floor_t push_floor;
    logic   pop;
    floor_t head_floor;
    logic   head_valid;
    logic   full;

    // Button sampling and request lights
    request_latch u_request_latch (
        .clock              (clock),
        .reset_n            (reset_n),
        .floor_call_buttons (floor_call_buttons),
        .panel_buttons      (panel_buttons),
        .emergency_button   (emergency_button),
        .power_switch       (power_switch),
        .car_status         (car_status),
        .full               (full),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights),
        .push               (push),
        .push_floor         (push_floor)
    );

    // Pending floors in arrival order
    request_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_request_queue (
        .clock      (clock),
        .reset_n    (reset_n),
        .push       (push),
        .push_floor (push_floor),
        .pop        (pop),
        .head_floor (head_floor),
        .head_valid (head_valid),
        .full       (full)
    );

    // Oldest request drives the car
    car_dispatch u_car_dispatch (
        .power_switch       (power_switch),
        .emergency_button   (emergency_button),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .car_status         (car_status),
        .head_floor         (head_floor),
        .head_valid         (head_valid),
        .car_command        (car_command),
        .pop                (pop),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

//--- verification/floor_controller_tests.svh
//////////////////////////////////////////////////////////////////////
// Stimulus and expected value rows for the floor controller testbench
// Rows are applied in order, one clock cycle each
//////////////////////////////////////////////////////////////////////

`ifndef FLOOR_CONTROLLER_TESTS_SVH
`define FLOOR_CONTROLLER_TESTS_SVH

// Columns: test, call, panel, door open, door close, emergency, power, floor, moving,
// then expected call lights, panel lights, target, up, activate, door open, door close
task automatic load_table();
    // Idle right after reset
    add_row(1, 11'h000, 11'h000, 0, 0, 0, 1, 0, 0, 11'h000, 11'h000, 0, 0, 0, 0, 0);

    // Single request from floor 0, then the current floor button, then arrival
    add_row(2, 11'h000, 11'h010, 0, 0, 0, 1, 0, 0, 11'h000, 11'h010, 4, 1, 1, 0, 0);
    add_row(2, 11'h000, 11'h001, 0, 0, 0, 1, 0, 0, 11'h000, 11'h010, 4, 1, 1, 0, 0);
    add_row(2, 11'h000, 11'h000, 0, 0, 0, 1, 4, 0, 11'h000, 11'h000, 0, 0, 0, 0, 0);

    // Panel 2, call 1 and call 7 held with the car above at floor 4
    add_row(3, 11'h082, 11'h004, 0, 0, 0, 1, 4, 0, 11'h000, 11'h004, 2, 0, 1, 0, 0);
    add_row(3, 11'h082, 11'h004, 0, 0, 0, 1, 4, 0, 11'h002, 11'h004, 2, 0, 1, 0, 0);
    add_row(3, 11'h082, 11'h004, 0, 0, 0, 1, 4, 0, 11'h082, 11'h004, 2, 0, 1, 0, 0);
    add_row(3, 11'h082, 11'h004, 0, 0, 0, 1, 4, 0, 11'h082, 11'h004, 2, 0, 1, 0, 0);

    // Passing floor 2 while moving, then stops at 2, 1 and 7
    add_row(4, 11'h000, 11'h000, 0, 0, 0, 1, 2, 1, 11'h082, 11'h004, 2, 0, 0, 0, 0);
    add_row(4, 11'h000, 11'h000, 0, 0, 0, 1, 2, 0, 11'h082, 11'h000, 1, 0, 1, 0, 0);
    add_row(4, 11'h000, 11'h000, 0, 0, 0, 1, 1, 0, 11'h080, 11'h000, 7, 1, 1, 0, 0);
    add_row(4, 11'h000, 11'h000, 0, 0, 0, 1, 7, 0, 11'h000, 11'h000, 0, 0, 0, 0, 0);

    // Emergency, power off, then a full queue holding off panel 2
    add_row(5, 11'h000, 11'h001, 0, 0, 0, 1, 7, 0, 11'h000, 11'h001, 0, 0, 1, 0, 0);
    add_row(5, 11'h008, 11'h000, 0, 0, 1, 1, 7, 0, 11'h000, 11'h001, 0, 0, 0, 0, 0);
    add_row(5, 11'h008, 11'h000, 1, 1, 0, 0, 7, 0, 11'h000, 11'h001, 0, 0, 0, 0, 0);
    add_row(5, 11'h228, 11'h000, 0, 0, 0, 1, 7, 0, 11'h008, 11'h001, 0, 0, 1, 0, 0);
    add_row(5, 11'h228, 11'h000, 0, 0, 0, 1, 7, 0, 11'h028, 11'h001, 0, 0, 1, 0, 0);
    add_row(5, 11'h228, 11'h000, 0, 0, 0, 1, 7, 0, 11'h228, 11'h001, 0, 0, 1, 0, 0);
    add_row(5, 11'h228, 11'h004, 0, 0, 0, 1, 7, 0, 11'h228, 11'h001, 0, 0, 1, 0, 0);
    add_row(5, 11'h228, 11'h004, 0, 0, 0, 1, 0, 0, 11'h228, 11'h000, 3, 1, 1, 0, 0);
    add_row(5, 11'h228, 11'h004, 0, 0, 0, 1, 0, 0, 11'h228, 11'h004, 3, 1, 1, 0, 0);

    // Door buttons while stopped, then while moving
    add_row(6, 11'h000, 11'h000, 1, 0, 0, 1, 0, 0, 11'h228, 11'h004, 3, 1, 1, 1, 0);
    add_row(6, 11'h000, 11'h000, 0, 1, 0, 1, 0, 0, 11'h228, 11'h004, 3, 1, 1, 0, 1);
    add_row(6, 11'h000, 11'h000, 1, 1, 0, 1, 0, 1, 11'h228, 11'h004, 3, 1, 0, 0, 0);
    add_row(6, 11'h000, 11'h000, 1, 1, 0, 1, 0, 0, 11'h228, 11'h004, 3, 1, 1, 1, 1);
endtask

`endif

//--- verification/floor_controller_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the elevator floor request controller
// Clock, reset, table driven row loop and compare task
// Per test result lines, cycle watchdog and closing summary
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module floor_controller_tb;

    import elevator_pkg::*;

    localparam int QUEUE_DEPTH  = 4;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_ROWS     = 32;

    // One table row with the stimulus ahead of the expected responses
    typedef struct packed {
        logic [7:0]   test;
        floor_mask_t  call_buttons;
        floor_mask_t  panel_buttons;
        logic         door_open;
        logic         door_close;
        logic         emergency;
        logic         power;
        car_status_t  status;
        floor_mask_t  exp_call;
        floor_mask_t  exp_panel;
        car_command_t exp_command;
        logic         exp_door_open;
        logic         exp_door_close;
    } row_t;

    logic         clock;
    logic         reset_n;
    floor_mask_t  floor_call_buttons;
    floor_mask_t  panel_buttons;
    logic         door_open_button;
    logic         door_close_button;
    logic         emergency_button;
    logic         power_switch;
    car_status_t  car_status;
    car_command_t car_command;
    floor_mask_t  call_lights;
    floor_mask_t  panel_lights;
    logic         door_open_allowed;
    logic         door_close_allowed;

    row_t table_rows [MAX_ROWS];
    int   row_count    = 0;
    int   cycle_count  = 0;
    int   cycle_limit  = 0;
    int   error_count  = 0;
    int   test_errors  = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    int   current_test = 1;
    int   current_row  = -1;

    floor_controller #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) uut (
        .clock              (clock),
        .reset_n            (reset_n),
        .floor_call_buttons (floor_call_buttons),
        .panel_buttons      (panel_buttons),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .emergency_button   (emergency_button),
        .power_switch       (power_switch),
        .car_status         (car_status),
        .car_command        (car_command),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Watchdog on the total run length
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic add_row(input int test, input floor_mask_t call, input floor_mask_t panel,
                           input logic door_open, input logic door_close,
                           input logic emergency, input logic power,
                           input floor_t floor, input logic moving,
                           input floor_mask_t exp_call, input floor_mask_t exp_panel,
                           input floor_t exp_target, input logic exp_up, input logic exp_act,
                           input logic exp_door_open, input logic exp_door_close);
        row_t row;
        row.test                     = 8'(test);
        row.call_buttons             = call;
        row.panel_buttons            = panel;
        row.door_open                = door_open;
        row.door_close               = door_close;
        row.emergency                = emergency;
        row.power                    = power;
        row.status.current_floor     = floor;
        row.status.moving            = moving;
        row.exp_call                 = exp_call;
        row.exp_panel                = exp_panel;
        row.exp_command.target_floor = exp_target;
        row.exp_command.direction_up = exp_up;
        row.exp_command.activate     = exp_act;
        row.exp_door_open            = exp_door_open;
        row.exp_door_close           = exp_door_close;
        if (row_count < MAX_ROWS) begin
            table_rows[row_count] = row;
            row_count = row_count + 1;
        end else begin
            $display("Table overflow: more than %0d rows were given", MAX_ROWS);
            error_count = error_count + 1;
        end
    endtask

    `include "floor_controller_tests.svh"

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h (test %0d, row %0d)",
                     name, actual, expected, current_test, current_row);
            error_count = error_count + 1;
            test_errors = test_errors + 1;
        end
    endtask

    task automatic apply_row(input int index);
        current_row        = index;
        current_test       = table_rows[index].test;
        floor_call_buttons = table_rows[index].call_buttons;
        panel_buttons      = table_rows[index].panel_buttons;
        door_open_button   = table_rows[index].door_open;
        door_close_button  = table_rows[index].door_close;
        emergency_button   = table_rows[index].emergency;
        power_switch       = table_rows[index].power;
        car_status         = table_rows[index].status;
    endtask

    task automatic check_row(input int index);
        check_value("call_lights", 16'(call_lights), 16'(table_rows[index].exp_call));
        check_value("panel_lights", 16'(panel_lights), 16'(table_rows[index].exp_panel));
        check_value("target_floor", 16'(car_command.target_floor),
                    16'(table_rows[index].exp_command.target_floor));
        check_value("direction_up", 16'(car_command.direction_up),
                    16'(table_rows[index].exp_command.direction_up));
        check_value("activate", 16'(car_command.activate),
                    16'(table_rows[index].exp_command.activate));
        check_value("door_open_allowed", 16'(door_open_allowed),
                    16'(table_rows[index].exp_door_open));
        check_value("door_close_allowed", 16'(door_close_allowed),
                    16'(table_rows[index].exp_door_close));
    endtask

    task automatic finish_test(input int test);
        if (test_errors == 0) begin
            tests_passed = tests_passed + 1;
            $display("Test %0d: ok", test);
        end else begin
            tests_failed = tests_failed + 1;
            $display("Test %0d: failed with %0d mismatches", test, test_errors);
        end
        test_errors = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic last_of_test;
        load_table();
        cycle_limit        = 2 * row_count + RESET_CYCLES;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_button   = 1'b0;
        door_close_button  = 1'b0;
        emergency_button   = 1'b0;
        power_switch       = 1'b1;
        car_status         = '0;

        // Outputs stay quiet while reset is held
        repeat (RESET_CYCLES / 2) @(posedge clock);
        #5;
        check_value("call_lights", 16'(call_lights), 16'h0);
        check_value("panel_lights", 16'(panel_lights), 16'h0);
        check_value("activate", 16'(car_command.activate), 16'h0);
        check_value("door_open_allowed", 16'(door_open_allowed), 16'h0);
        check_value("door_close_allowed", 16'(door_close_allowed), 16'h0);
        repeat (RESET_CYCLES - RESET_CYCLES / 2) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        for (int r = 0; r < row_count; r++) begin
            @(negedge clock);
            apply_row(r);
            @(posedge clock);
            #5;
            check_row(r);
            if (r == row_count - 1) begin
                last_of_test = 1'b1;
            end else begin
                last_of_test = (table_rows[r + 1].test != table_rows[r].test);
            end
            if (last_of_test) begin
                finish_test(table_rows[r].test);
            end
        end

        $display("Summary: %0d tests ok, %0d tests with errors, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+verification
common/elevator_pkg.sv
hdl/request_latch.sv
hdl/request_queue.sv
hdl/car_dispatch.sv
hdl/floor_controller.sv
verification/floor_controller_tb.sv

//--- Bender.yml
package:
  name: floor_controller

sources:
  - files:
      - common/elevator_pkg.sv
      - hdl/request_latch.sv
      - hdl/request_queue.sv
      - hdl/car_dispatch.sv
      - hdl/floor_controller.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/floor_controller_tb.sv
